//--- include/xr_basic_regmap.svh
// register map of the basic reconfig CSR block, included by xr_basic_pkg only
// word addresses are 3 bits, opcodes sit in writedata[3:0] of a control write
`ifndef XR_BASIC_REGMAP_SVH
`define XR_BASIC_REGMAP_SVH

//////////////////////////////
// host word addresses
//////////////////////////////
localparam logic [2:0] ADDR_LCH     = 3'd1;  // logical channel, rd/wr
localparam logic [2:0] ADDR_PCH_MAP = 3'd2;  // physical if/channel of current lch, rd only
localparam logic [2:0] ADDR_CTRL    = 3'd3;  // wr opcode, rd status
localparam logic [2:0] ADDR_OFFSET  = 3'd4;  // native offset or raw address
localparam logic [2:0] ADDR_DATA    = 3'd5;  // native write data / captured read data

//////////////////////////////
// control opcodes
//////////////////////////////
localparam logic [3:0] OPC_RECO_WRITE  = 4'd1;  // one native write
localparam logic [3:0] OPC_RECO_READ   = 4'd2;  // fixed length native read
localparam logic [3:0] OPC_PLOCK_SET   = 4'd3;
localparam logic [3:0] OPC_PLOCK_CLEAR = 4'd4;
localparam logic [3:0] OPC_INCR_SET    = 4'd5;  // data write triggers write + addr++
localparam logic [3:0] OPC_INCR_CLEAR  = 4'd6;
localparam logic [3:0] OPC_LADDR_SET   = 4'd7;  // offset is relative to channel
localparam logic [3:0] OPC_PADDR_SET   = 4'd8;  // offset is a raw native address

//////////////////////////////
// status bits, read at ADDR_CTRL
//////////////////////////////
localparam int STAT_PLOCK_GRANTED = 0;
localparam int STAT_PLOCK_REQ     = 1;
localparam int STAT_PHYS_ADDR     = 2;
localparam int STAT_AUTO_INCR     = 3;

`endif

//--- hdl/xr_basic_pkg.sv
// shared widths, sequence counts and the fixed logical-to-physical table
// table rule is fixed: interface = lch / 3, channel = lch % 3
package xr_basic_pkg;

  `include "xr_basic_regmap.svh"

  // field widths
  localparam int W_LCH   = 5;   // logical channel number
  localparam int W_PIF   = 5;   // physical interface number
  localparam int W_PCH   = 3;   // channel within a physical interface
  localparam int W_PADDR = 12;  // native address, msb forces physical mode
  localparam int W_OFFS  = 9;   // in-channel offset bits
  localparam int W_RDATA = 16;  // native readdata

  localparam int W_L2P       = W_PIF + W_PCH;  // one table entry, {pif, pch}
  localparam int L2P_ENTRIES = 2 ** W_LCH;

  //////////////////////////////
  // native sequence timing
  //////////////////////////////
  // read strobe while count is 6..3, readdata captured at 2
  localparam logic [2:0] READ_START_COUNT   = 3'd6;
  localparam logic [2:0] READ_CAPTURE_COUNT = 3'd2;

  // cycles until a new native address is ready, per kind of change
  localparam logic [1:0] LOAD_AFTER_LCH    = 2'd3;
  localparam logic [1:0] LOAD_AFTER_OFFSET = 2'd2;
  localparam logic [1:0] LOAD_AFTER_MODE   = 2'd1;

  // build the mapping table, three channels per physical interface
  function automatic logic [L2P_ENTRIES-1:0][W_L2P-1:0] l2p_build();
    logic [L2P_ENTRIES-1:0][W_L2P-1:0] tbl;
    for (int i = 0; i < L2P_ENTRIES; i++) begin
      tbl[i] = {W_PIF'(i / 3), W_PCH'(i % 3)};  // interface above channel
    end
    return tbl;
  endfunction

  localparam logic [L2P_ENTRIES-1:0][W_L2P-1:0] L2P_TABLE = l2p_build();

endpackage

//--- hdl/xr_basic_l2p_map.sv
// logical to physical channel lookup through the fixed package table
// all outputs lag reg_lch / reg_addr by one cycle
`timescale 1ns/10ps

module xr_basic_l2p_map import xr_basic_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  input  logic [W_LCH-1:0]   reg_lch,
  input  logic [W_PADDR-1:0] reg_addr,
  output logic [W_LCH-1:0]   lif_number,  // logical channel, registered copy
  output logic [W_PIF-1:0]   pif_number,
  output logic [W_PCH-1:0]   pch_number,
  output logic [W_PADDR-1:0] l2p_addr     // {channel, low offset bits}
);

  logic [W_L2P-1:0] entry;  // {pif, pch} for the current channel

  assign entry = L2P_TABLE[reg_lch];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      lif_number <= '0;
      pif_number <= '0;
      pch_number <= '0;
      l2p_addr   <= '0;
    end else begin
      lif_number <= reg_lch;
      pif_number <= entry[W_L2P-1:W_PCH];
      pch_number <= entry[W_PCH-1:0];
      // channel number sits above the in-channel offset
      l2p_addr   <= {entry[W_PCH-1:0], reg_addr[W_OFFS-1:0]};
    end
  end

endmodule

//--- hdl/xr_basic_bus.sv
// host side of the basic CSR: avalon style write/read with waitrequest
// the host must hold its request until waitrequest is sampled low
`timescale 1ns/10ps

module xr_basic_bus import xr_basic_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  input  logic               write,
  input  logic               read,
  input  logic [2:0]         address,
  input  logic [W_LCH-1:0]   reg_lch,
  input  logic [W_PADDR-1:0] reg_addr,
  input  logic [31:0]        reg_rwdata,
  input  logic               plock_req,
  input  logic               phys_mode,
  input  logic               auto_incr,
  input  logic               plock_granted,
  input  logic [W_PIF-1:0]   pif_number,
  input  logic [W_PCH-1:0]   pch_number,
  input  logic               read_busy,      // native read still running
  output logic [31:0]        readdata,
  output logic               waitrequest,
  output logic               wr_lch,         // accepted write pulses, one cycle each
  output logic               wr_offset,
  output logic               wr_data,
  output logic               wr_ctrl
);

  logic        in_wait;   // waitrequest of the previous cycle
  logic        lch_wait;  // second wait cycle of a channel write
  logic        first;     // first cycle of a request
  logic [31:0] status;    // status word at ADDR_CTRL

  assign first = ~in_wait;

  // write strobes, only on the first cycle so a held request fires once
  assign wr_lch    = write & first & (address == ADDR_LCH);
  assign wr_offset = write & first & (address == ADDR_OFFSET);
  assign wr_data   = write & first & (address == ADDR_DATA);
  assign wr_ctrl   = write & first & (address == ADDR_CTRL);

  // wait states
  //   channel write 2, offset write 1, other writes 0
  //   any read 1, data read stretched while the native read runs
  assign waitrequest = (write & (first | lch_wait) & (address == ADDR_LCH))
                     | (wr_offset)
                     | (read & first)
                     | (read & read_busy & (address == ADDR_DATA));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      in_wait  <= 1'b0;
      lch_wait <= 1'b0;
    end else begin
      in_wait  <= waitrequest;
      lch_wait <= wr_lch;  // channel needs time to reach the l2p table
    end
  end

  always_comb begin
    status                     = '0;
    status[STAT_PLOCK_GRANTED] = plock_granted;
    status[STAT_PLOCK_REQ]     = plock_req;
    status[STAT_PHYS_ADDR]     = phys_mode;
    status[STAT_AUTO_INCR]     = auto_incr;
  end

  //////////////////////////////
  // readdata mux, registered
  //////////////////////////////
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      readdata <= '0;
    end else begin
      case (address)
        ADDR_LCH:     readdata <= {{(32-W_LCH){1'b0}}, reg_lch};
        ADDR_PCH_MAP: readdata <= {{(32-W_L2P){1'b0}}, pif_number, pch_number};
        ADDR_CTRL:    readdata <= status;
        ADDR_OFFSET:  readdata <= {{(32-W_PADDR){1'b0}}, reg_addr};
        ADDR_DATA:    readdata <= reg_rwdata;
        default:      readdata <= '1;  // unmapped words read all ones
      endcase
    end
  end

endmodule

//--- hdl/xr_basic_regs.sv
// channel, offset, data and mode registers of the basic CSR, plus opcode decode
// mode bits follow the arbiter while lif_is_active was low and no control write
`timescale 1ns/10ps

module xr_basic_regs import xr_basic_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  input  logic [31:0]        writedata,
  input  logic               wr_lch,
  input  logic               wr_offset,
  input  logic               wr_data,
  input  logic               wr_ctrl,
  input  logic               lif_is_active,  // arbiter owns this logical interface
  input  logic               rdata_capture,  // native readdata valid this cycle
  input  logic [W_RDATA-1:0] reco_rdata,
  output logic [W_LCH-1:0]   reg_lch,
  output logic [W_PADDR-1:0] reg_addr,
  output logic [31:0]        reg_rwdata,
  output logic               plock_get,
  output logic               phys_mode,
  output logic               auto_incr,
  output logic               read_req,       // request pulses to the sequencer
  output logic               write_req,
  output logic               mode_chg,
  output logic               incr_step
);

  logic [3:0] opcode;
  logic       lif_active_last;  // lif_is_active of the previous cycle
  logic       plock;

  assign opcode    = writedata[3:0];
  assign plock_get = plock;

  //////////////////////////////
  // opcode decode
  //////////////////////////////
  assign read_req  = wr_ctrl & (opcode == OPC_RECO_READ);
  assign write_req = wr_ctrl & (opcode == OPC_RECO_WRITE);
  assign mode_chg  = wr_ctrl & ((opcode == OPC_LADDR_SET) | (opcode == OPC_PADDR_SET));
  assign incr_step = auto_incr & wr_data;  // data write in auto mode: write + addr++

  // logical channel
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      reg_lch <= '0;
    end else if (wr_lch) begin
      reg_lch <= writedata[W_LCH-1:0];
    end
  end

  // offset or raw address, host write wins over increment
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      reg_addr <= '0;
    end else if (wr_offset) begin
      reg_addr <= writedata[W_PADDR-1:0];
    end else if (incr_step) begin
      reg_addr <= reg_addr + 1'b1;
    end
  end

  // data word, also holds native readdata after a read opcode
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      reg_rwdata <= '0;
    end else if (wr_data) begin
      reg_rwdata <= writedata;
    end else if (rdata_capture) begin
      reg_rwdata <= {{(32-W_RDATA){1'b0}}, reco_rdata};  // zero extended
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      lif_active_last <= 1'b0;
    end else begin
      lif_active_last <= lif_is_active;
    end
  end

  //////////////////////////////
  // mode bits
  //////////////////////////////
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      plock     <= 1'b0;
      auto_incr <= 1'b0;
      phys_mode <= 1'b0;
    end else if (wr_ctrl) begin
      if (opcode == OPC_PLOCK_CLEAR) plock <= 1'b0;
      else if (opcode == OPC_PLOCK_SET) plock <= 1'b1;

      if (opcode == OPC_INCR_CLEAR) auto_incr <= 1'b0;
      else if (opcode == OPC_INCR_SET) auto_incr <= 1'b1;

      if (opcode == OPC_LADDR_SET) phys_mode <= 1'b0;
      else if (opcode == OPC_PADDR_SET) phys_mode <= 1'b1;
    end else if (!lif_active_last) begin
      // interface was released, lock tracks the arbiter and modes drop
      plock     <= lif_is_active;
      auto_incr <= 1'b0;
      phys_mode <= 1'b0;
    end
  end

endmodule

//--- hdl/xr_basic_reco_seq.sv
// native reconfig sequencer, fixed latency and no back-pressure on the native side
// reco_read spans 4 cycles, readdata is taken 1 cycle after the strobe ends
`timescale 1ns/10ps

module xr_basic_reco_seq import xr_basic_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  input  logic               read_req,
  input  logic               write_req,
  input  logic               incr_step,
  input  logic               wr_lch,
  input  logic               wr_offset,
  input  logic               mode_chg,
  input  logic               phys_mode,
  input  logic               auto_incr,
  input  logic [W_PADDR-1:0] reg_addr,
  input  logic [W_PADDR-1:0] l2p_addr,   // channel relative address, already mapped
  output logic               reco_read,
  output logic               reco_write,
  output logic [W_PADDR-1:0] reco_addr,
  output logic               read_busy,
  output logic               rdata_capture
);

  logic [2:0] read_cnt;  // 6 -> 0 over one native read
  logic [1:0] load_cnt;  // waits for new lch/offset/mode to settle

  //////////////////////////////
  // read length counter
  //////////////////////////////
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      read_cnt <= '0;
    end else if (read_req) begin
      read_cnt <= READ_START_COUNT;
    end else if (read_cnt != '0) begin
      read_cnt <= read_cnt - 3'd1;
    end
  end

  assign reco_read     = read_cnt > READ_CAPTURE_COUNT;   // counts 6,5,4,3
  assign rdata_capture = read_cnt == READ_CAPTURE_COUNT;
  assign read_busy     = read_cnt != '0;

  // one write pulse per opcode or auto-increment data write
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      reco_write <= 1'b0;
    end else begin
      reco_write <= write_req | incr_step;
    end
  end

  //////////////////////////////
  // native address loading
  //////////////////////////////
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      load_cnt <= '0;
    end else if (wr_lch) begin
      load_cnt <= LOAD_AFTER_LCH;     // lch reg, then table lookup
    end else if (wr_offset) begin
      load_cnt <= LOAD_AFTER_OFFSET;  // offset reg, then l2p_addr
    end else if (mode_chg) begin
      load_cnt <= LOAD_AFTER_MODE;
    end else if (load_cnt != '0) begin
      load_cnt <= load_cnt - 2'd1;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      reco_addr <= '0;
    end else if (load_cnt == 2'd1) begin
      // raw address in physical mode or when the offset msb is set
      if (phys_mode || reg_addr[W_PADDR-1]) reco_addr <= reg_addr;
      else reco_addr <= l2p_addr;
    end else if (auto_incr && reco_write) begin
      reco_addr <= reco_addr + 1'b1;  // step past the word just written
    end
  end

endmodule

//--- hdl/xr_basic_top.sv
// basic reconfig CSR, logical side, for one logical interface
// reg_rwdata carries the native write data next to reco_write
`timescale 1ns/10ps

module xr_basic_top import xr_basic_pkg::*; (
  input  logic               reconfig_clk,
  input  logic               reset,
  // host bus
  input  logic               write,
  input  logic               read,
  input  logic [2:0]         address,
  input  logic [31:0]        writedata,
  output logic [31:0]        readdata,
  output logic               waitrequest,
  // arbiter side
  input  logic               lif_is_active,
  input  logic               plock_granted,
  output logic               plock_get,
  output logic [W_LCH-1:0]   lif_number,
  output logic [W_PIF-1:0]   pif_number,
  output logic [W_PCH-1:0]   pch_number,
  // native reconfig
  output logic               reco_read,
  output logic               reco_write,
  output logic [W_PADDR-1:0] reco_addr,
  output logic [31:0]        reg_rwdata,   // write data, low 16 bits used
  input  logic [W_RDATA-1:0] reco_rdata
);

  logic               wr_lch, wr_offset, wr_data, wr_ctrl;  // accepted writes
  logic [W_LCH-1:0]   reg_lch;
  logic [W_PADDR-1:0] reg_addr;
  logic [W_PADDR-1:0] l2p_addr;
  logic               phys_mode, auto_incr;
  logic               read_req, write_req, mode_chg, incr_step;
  logic               read_busy, rdata_capture;

  xr_basic_bus bus_inst (
    .clock(reconfig_clk), .reset(reset),
    .write(write), .read(read), .address(address),
    .reg_lch(reg_lch), .reg_addr(reg_addr), .reg_rwdata(reg_rwdata),
    .plock_req(plock_get), .phys_mode(phys_mode), .auto_incr(auto_incr),
    .plock_granted(plock_granted), .pif_number(pif_number), .pch_number(pch_number),
    .read_busy(read_busy), .readdata(readdata), .waitrequest(waitrequest),
    .wr_lch(wr_lch), .wr_offset(wr_offset), .wr_data(wr_data), .wr_ctrl(wr_ctrl)
  );

  xr_basic_regs regs_inst (
    .clock(reconfig_clk), .reset(reset), .writedata(writedata),
    .wr_lch(wr_lch), .wr_offset(wr_offset), .wr_data(wr_data), .wr_ctrl(wr_ctrl),
    .lif_is_active(lif_is_active), .rdata_capture(rdata_capture), .reco_rdata(reco_rdata),
    .reg_lch(reg_lch), .reg_addr(reg_addr), .reg_rwdata(reg_rwdata),
    .plock_get(plock_get), .phys_mode(phys_mode), .auto_incr(auto_incr),
    .read_req(read_req), .write_req(write_req), .mode_chg(mode_chg), .incr_step(incr_step)
  );

  xr_basic_reco_seq seq_inst (
    .clock(reconfig_clk), .reset(reset),
    .read_req(read_req), .write_req(write_req), .incr_step(incr_step),
    .wr_lch(wr_lch), .wr_offset(wr_offset), .mode_chg(mode_chg),
    .phys_mode(phys_mode), .auto_incr(auto_incr), .reg_addr(reg_addr), .l2p_addr(l2p_addr),
    .reco_read(reco_read), .reco_write(reco_write), .reco_addr(reco_addr),
    .read_busy(read_busy), .rdata_capture(rdata_capture)
  );

  xr_basic_l2p_map map_inst (
    .clock(reconfig_clk), .reset(reset), .reg_lch(reg_lch), .reg_addr(reg_addr),
    .lif_number(lif_number), .pif_number(pif_number), .pch_number(pch_number),
    .l2p_addr(l2p_addr)
  );

endmodule

//--- bench/reco_model.sv
// native reconfig memory and lock arbiter stand-in, simulation only
// readdata lags reco_addr by one clock, a write stores the low 16 data bits
`timescale 1ns/10ps

module reco_model (
  input  logic        reconfig_clk,
  input  logic        reset,
  input  logic        reco_write,
  input  logic [11:0] reco_addr,
  input  logic [15:0] wdata,          // low half of reg_rwdata
  input  logic        plock_get,
  output logic [15:0] reco_rdata,
  output logic        plock_granted
);

  logic [15:0] mem [0:4095];  // 4096 x 16 native space

  // fill pattern, every address bit shows in the word
  initial begin
    for (int i = 0; i < 4096; i++) begin
      mem[i] = {i[3:0], i[11:0]} ^ 16'h5a5a;
    end
  end

  always @(posedge reconfig_clk) begin
    if (reco_write) mem[reco_addr] <= wdata;
    reco_rdata <= mem[reco_addr];  // old word on a same-cycle write
  end

  // grant follows the request one clock later
  always @(posedge reconfig_clk or posedge reset) begin
    if (reset) begin
      plock_granted <= 1'b0;
    end else begin
      plock_granted <= plock_get;
    end
  end

endmodule

//--- bench/xr_basic_tb.sv
// testbench for the basic reconfig CSR, host inputs change 1 ns after the rising edge
// lif_is_active stays high except in the arbiter section, outputs sampled at negedge
`timescale 1ns/10ps

module xr_basic_tb import xr_basic_pkg::*; ();

  localparam int WAIT_LIMIT = 50;  // cycles before any wait gives up

  logic               reconfig_clk;
  logic               reset;
  logic               write, read;
  logic [2:0]         address;
  logic [31:0]        writedata, readdata;
  logic               waitrequest;
  logic               lif_is_active, plock_granted, plock_get;
  logic [W_LCH-1:0]   lif_number;
  logic [W_PIF-1:0]   pif_number;
  logic [W_PCH-1:0]   pch_number;
  logic               reco_read, reco_write;
  logic [W_PADDR-1:0] reco_addr;
  logic [31:0]        reg_rwdata;
  logic [W_RDATA-1:0] reco_rdata;
  int                 errors;    // wrong values
  int                 timeouts;  // waits that ran out

  xr_basic_top xr_basic_top_inst (.*);

  reco_model model_inst (
    .reconfig_clk, .reset, .reco_write, .reco_addr, .wdata(reg_rwdata[15:0]),
    .plock_get, .reco_rdata, .plock_granted
  );

  initial reconfig_clk = 1'b0;
  always #50 reconfig_clk = ~reconfig_clk;  // 100 ns period

  //////////////////////////////
  // host access and checks
  //////////////////////////////
  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // request held until waitrequest is seen low, then released after that edge
  task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
    int n;
    @(posedge reconfig_clk);
    #1;
    write = 1'b1;
    address = addr;
    writedata = data;
    n = 0;
    @(negedge reconfig_clk);
    while (waitrequest && n < WAIT_LIMIT) begin
      @(negedge reconfig_clk);
      n++;
    end
    if (waitrequest) begin
      timeouts++;
      $display("timeout: write to word %0d was never accepted", addr);
    end else begin
      // channel write 2 waits, offset write 1, others none
      expect_eq("write wait cycles", n, (addr == ADDR_LCH) ? 2 : (addr == ADDR_OFFSET) ? 1 : 0);
    end
    @(posedge reconfig_clk);
    #1;
    write = 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
    int n;
    @(posedge reconfig_clk);
    #1;
    read = 1'b1;
    address = addr;
    n = 0;
    @(negedge reconfig_clk);
    while (waitrequest && n < WAIT_LIMIT) begin
      @(negedge reconfig_clk);
      n++;
    end
    if (waitrequest) begin
      timeouts++;
      $display("timeout: read of word %0d was never accepted", addr);
    end else if (addr != ADDR_DATA) begin
      expect_eq("read wait cycles", n, 1);  // data word may stretch over a native read
    end
    data = readdata;  // valid on the cycle the wait drops
    @(posedge reconfig_clk);
    #1;
    read = 1'b0;
  endtask

  // read opcode, then the length of the native read strobe in cycles
  task automatic run_native_read(output int width);
    int n;
    write_reg(ADDR_CTRL, OPC_RECO_READ);
    width = 0;
    n = 0;
    @(negedge reconfig_clk);
    while (!reco_read && n < WAIT_LIMIT) begin
      @(negedge reconfig_clk);
      n++;
    end
    if (!reco_read) begin
      timeouts++;
      $display("timeout: reco_read never rose after the read opcode");
    end
    while (reco_read && width < WAIT_LIMIT) begin
      width++;
      @(negedge reconfig_clk);
    end
  endtask

  task automatic wait_plock(input logic level);
    int n;
    n = 0;
    @(negedge reconfig_clk);
    while (plock_get !== level && n < WAIT_LIMIT) begin
      @(negedge reconfig_clk);
      n++;
    end
    if (plock_get !== level) begin
      timeouts++;
      $display("timeout: plock_get did not reach %b", level);
    end
  endtask

  // channel number above the low 9 offset bits
  function automatic logic [11:0] logical_addr(input int lch, input logic [31:0] offs);
    return 12'(((lch % 3) << 9) | (offs & 32'h1ff));
  endfunction

  //////////////////////////////
  // stimulus
  //////////////////////////////
  initial begin
    int          lch;
    int          w;
    int unsigned seed_ret;
    logic [31:0] rd, wd, offs;
    logic [31:0] burst [4];
    seed_ret = $urandom(32'h1bd2);
    errors = 0;
    timeouts = 0;
    reset = 1'b1;
    write = 1'b0;
    read = 1'b0;
    address = '0;
    writedata = '0;
    lif_is_active = 1'b1;
    repeat (16) @(posedge reconfig_clk);
    #1;
    reset = 1'b0;
    expect_eq("reco_read after reset", reco_read, 0);
    expect_eq("reco_write after reset", reco_write, 0);

    // register readback and unmapped words
    write_reg(ADDR_LCH, 32'd7);
    read_reg(ADDR_LCH, rd);
    expect_eq("channel readback", rd, 7);
    wd = $urandom();
    write_reg(ADDR_OFFSET, wd);
    read_reg(ADDR_OFFSET, rd);
    expect_eq("offset readback", rd, wd & 32'hfff);  // 12 bit native address
    wd = $urandom();
    write_reg(ADDR_DATA, wd);
    read_reg(ADDR_DATA, rd);
    expect_eq("data readback", rd, wd);
    read_reg(3'd0, rd);
    expect_eq("unmapped word 0", rd, 32'hffff_ffff);
    read_reg(3'd7, rd);
    expect_eq("unmapped word 7", rd, 32'hffff_ffff);

    // mapping table, interface = lch / 3 and channel = lch % 3
    for (int i = 0; i < 6; i++) begin
      lch = (i == 0) ? 31 : $urandom_range(30, 0);
      write_reg(ADDR_LCH, lch);
      read_reg(ADDR_PCH_MAP, rd);
      expect_eq("pch map word", rd, ((lch / 3) << 3) | (lch % 3));
      expect_eq("pif_number", pif_number, lch / 3);
      expect_eq("pch_number", pch_number, lch % 3);
      expect_eq("lif_number", lif_number, lch);
    end

    // logical write then read back through a native read
    lch = 5;
    offs = $urandom_range(511, 0);
    wd = $urandom();
    write_reg(ADDR_LCH, lch);
    write_reg(ADDR_OFFSET, offs);
    write_reg(ADDR_DATA, wd);
    write_reg(ADDR_CTRL, OPC_RECO_WRITE);
    write_reg(ADDR_DATA, 32'h0);  // clear so the read has to refill it
    expect_eq("memory after logical write", model_inst.mem[logical_addr(lch, offs)], wd[15:0]);
    run_native_read(w);
    expect_eq("reco_read cycles", w, 4);
    read_reg(ADDR_DATA, rd);
    expect_eq("native read data", rd, {16'h0, wd[15:0]});

    // physical mode, raw offset
    write_reg(ADDR_CTRL, OPC_PADDR_SET);
    offs = $urandom_range(12'h3ff, 0);  // bits 10:9 never match channel 2 of lch 5
    wd = $urandom();
    write_reg(ADDR_OFFSET, offs);
    write_reg(ADDR_DATA, wd);
    write_reg(ADDR_CTRL, OPC_RECO_WRITE);
    write_reg(ADDR_CTRL, OPC_RECO_READ);
    read_reg(ADDR_DATA, rd);  // wait stretches over the running read
    expect_eq("physical read data", rd, {16'h0, wd[15:0]});
    expect_eq("memory after physical write", model_inst.mem[offs[11:0]], wd[15:0]);
    read_reg(ADDR_CTRL, rd);
    expect_eq("phys status bit", rd[STAT_PHYS_ADDR], 1'b1);

    // logical mode but offset msb set, still raw
    write_reg(ADDR_CTRL, OPC_LADDR_SET);
    offs = 32'h800 | $urandom_range(12'h7ff, 0);
    wd = $urandom();
    write_reg(ADDR_OFFSET, offs);
    write_reg(ADDR_DATA, wd);
    write_reg(ADDR_CTRL, OPC_RECO_WRITE);
    read_reg(ADDR_CTRL, rd);
    expect_eq("phys status bit after clear", rd[STAT_PHYS_ADDR], 1'b0);
    expect_eq("memory after msb write", model_inst.mem[offs[11:0]], wd[15:0]);

    // auto-increment burst in logical mode
    lch = $urandom_range(31, 0);
    offs = $urandom_range(500, 0);
    write_reg(ADDR_LCH, lch);
    write_reg(ADDR_OFFSET, offs);
    write_reg(ADDR_CTRL, OPC_INCR_SET);
    for (int i = 0; i < 4; i++) begin
      burst[i] = $urandom();
      write_reg(ADDR_DATA, burst[i]);  // each one writes and steps the address
    end
    read_reg(ADDR_OFFSET, rd);
    expect_eq("offset after burst", rd, offs + 4);
    read_reg(ADDR_CTRL, rd);
    expect_eq("auto incr status bit", rd[STAT_AUTO_INCR], 1'b1);
    for (int i = 0; i < 4; i++) begin
      expect_eq("burst memory word", model_inst.mem[logical_addr(lch, offs) + i], burst[i][15:0]);
    end
    write_reg(ADDR_CTRL, OPC_INCR_CLEAR);

    //////////////////////////////
    // lock and arbiter
    //////////////////////////////
    // lock already came up from the arbiter tie-in after reset, so clear it first
    write_reg(ADDR_CTRL, OPC_PLOCK_CLEAR);
    read_reg(ADDR_CTRL, rd);
    expect_eq("lock bits after clear", rd[1:0], 2'b00);
    expect_eq("plock_get after clear", plock_get, 0);
    write_reg(ADDR_CTRL, OPC_PLOCK_SET);
    read_reg(ADDR_CTRL, rd);
    expect_eq("lock req and grant", rd[1:0], 2'b11);
    expect_eq("plock_get after set", plock_get, 1);
    write_reg(ADDR_CTRL, OPC_PADDR_SET);
    write_reg(ADDR_CTRL, OPC_INCR_SET);
    read_reg(ADDR_CTRL, rd);
    expect_eq("all status bits set", rd[3:0], 4'b1111);
    @(posedge reconfig_clk);
    #1;
    lif_is_active = 1'b0;  // arbiter takes the interface away
    wait_plock(1'b0);
    read_reg(ADDR_CTRL, rd);
    expect_eq("status while inactive", rd, 32'h0);
    @(posedge reconfig_clk);
    #1;
    lif_is_active = 1'b1;
    wait_plock(1'b1);  // lock bit follows the arbiter back
    write_reg(ADDR_CTRL, OPC_PLOCK_CLEAR);
    read_reg(ADDR_CTRL, rd);
    expect_eq("status after release", rd, 32'h0);

    $display("value errors %0d, timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
hdl/xr_basic_pkg.sv
hdl/xr_basic_l2p_map.sv
hdl/xr_basic_bus.sv
hdl/xr_basic_regs.sv
hdl/xr_basic_reco_seq.sv
hdl/xr_basic_top.sv
bench/reco_model.sv
bench/xr_basic_tb.sv

//--- Bender.yml
package:
  name: xr_basic

sources:
  - include_dirs:
      - include
    files:
      - hdl/xr_basic_pkg.sv
      - hdl/xr_basic_l2p_map.sv
      - hdl/xr_basic_bus.sv
      - hdl/xr_basic_regs.sv
      - hdl/xr_basic_reco_seq.sv
      - hdl/xr_basic_top.sv
  - target: simulation
    files:
      - bench/reco_model.sv
      - bench/xr_basic_tb.sv
